// ==== source/gw_noc_pkg.sv ====
`default_nettype none

package gw_noc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Wormhole flit geometry
  //////////////////////////////////////////////////////////////////////

  localparam int flit_width_c = 32;
  localparam int len_width_c  = 2;
  localparam int op_width_c   = 2;
  localparam int addr_width_c = 16;
  localparam int pad_width_c  = flit_width_c - len_width_c - op_width_c - addr_width_c;

  // Header view, len counts the payload flits behind it
  typedef struct packed {
    logic [len_width_c-1:0]  len;
    logic [op_width_c-1:0]   op;
    logic [addr_width_c-1:0] addr;
    logic [pad_width_c-1:0]  pad;
  } wh_header_s;

  // Same flit read either as a header or as a raw data word
  typedef union packed {
    wh_header_s              hdr;
    logic [flit_width_c-1:0] data;
  } wh_flit_u;

  //////////////////////////////////////////////////////////////////////
  // Link direction
  //////////////////////////////////////////////////////////////////////

  // ready travels against v and flit
  typedef struct packed {
    logic     v;
    wh_flit_u flit;
    logic     ready;
  } wh_link_s;

endpackage

`default_nettype wire

// ==== source/gw_mc_pkg.sv ====
`default_nettype none

package gw_mc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Manycore packet fields
  //////////////////////////////////////////////////////////////////////

  localparam int mc_addr_width_c = 16;
  localparam int mc_data_width_c = 32;

  // Store acknowledge only shows up in responses
  typedef enum logic [1:0] {
    mc_op_load  = 2'd0,
    mc_op_store = 2'd1,
    mc_op_ack   = 2'd2
  } mc_op_e;

  typedef struct packed {
    mc_op_e                     op;
    logic [mc_addr_width_c-1:0] addr;
    logic [mc_data_width_c-1:0] data;
  } mc_req_s;

  typedef struct packed {
    mc_op_e                     op;
    logic [mc_data_width_c-1:0] data;
  } mc_resp_s;

  //////////////////////////////////////////////////////////////////////
  // Tag payload
  //////////////////////////////////////////////////////////////////////

  // Reset sits in the LSB, first bit on the serial line
  typedef struct packed {
    logic padding;
    logic reset;
  } tag_payload_s;

endpackage

`default_nettype wire

// ==== source/gw_tag_client.sv ====
`default_nettype none

module gw_tag_client (
  input  logic                    hb_clk_i,
  input  logic                    rst_n_i,
  input  logic                    tag_en_i,
  input  logic                    tag_data_i,
  output logic                    tag_new_o,
  output gw_mc_pkg::tag_payload_s tag_payload_o
);

  localparam int payload_width_lp = $bits(gw_mc_pkg::tag_payload_s);

  logic [payload_width_lp-1:0] shift_r;
  logic                        en_r;

  //////////////////////////////////////////////////////////////////////
  // Serial capture and commit
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shift_r       <= '0;
      en_r          <= 1'b0;
      tag_new_o     <= 1'b0;
      tag_payload_o <= '0;
    end else begin
      en_r      <= tag_en_i;
      tag_new_o <= 1'b0;
      if (tag_en_i) begin
        // LSB first, new bits enter at the top
        shift_r <= {tag_data_i, shift_r[payload_width_lp-1:1]};
      end else if (en_r) begin
        // Falling enable commits the word
        tag_payload_o <= gw_mc_pkg::tag_payload_s'(shift_r);
        tag_new_o     <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // One commit per enable burst
  tag_new_single_pulse_a : assert property (
    @(posedge hb_clk_i) disable iff (!rst_n_i)
    tag_new_o |=> !tag_new_o
  ) else $error("tag_new_o high in two consecutive cycles");

endmodule

`default_nettype wire

// ==== source/gw_mc_to_wormhole.sv ====
`default_nettype none

module gw_mc_to_wormhole (
  input  logic                 hb_clk_i,
  input  logic                 rst_n_i,
  input  logic                 core_rst_i,
  input  logic                 req_v_i,
  input  gw_mc_pkg::mc_req_s   req_i,
  output logic                 req_ready_o,
  output logic                 resp_v_o,
  output gw_mc_pkg::mc_resp_s  resp_o,
  input  logic                 resp_ready_i,
  input  gw_noc_pkg::wh_link_s wh_i,
  output gw_noc_pkg::wh_link_s wh_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_send_hdr,
    st_send_data,
    st_recv_hdr,
    st_recv_data,
    st_hold_resp
  } state_e;

  state_e              state_r;
  state_e              state_n;
  logic                arst_n;
  logic                live_r;
  logic                is_store;
  logic                req_fire;
  logic                flit_in_fire;
  gw_mc_pkg::mc_req_s  req_r;
  gw_mc_pkg::mc_resp_s resp_r;

  // Either the chip reset or the tag reset holds the adapter
  assign arst_n = rst_n_i & ~core_rst_i;

  assign is_store     = (req_r.op == gw_mc_pkg::mc_op_store);
  // Host waits until the memory can take a header
  assign req_ready_o  = live_r && (state_r == st_idle) && wh_i.ready;
  assign req_fire     = req_v_i && req_ready_o;
  assign flit_in_fire = wh_i.v && wh_o.ready;

  assign resp_v_o = (state_r == st_hold_resp);
  assign resp_o   = resp_r;

  //////////////////////////////////////////////////////////////////////
  // Flit output and next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wh_o    = '0;
    state_n = state_r;
    case (state_r)
      st_idle: begin
        if (req_fire) state_n = st_send_hdr;
      end
      st_send_hdr: begin
        wh_o.v             = 1'b1;
        wh_o.flit.hdr.len  = is_store ? 2'd1 : 2'd0;
        wh_o.flit.hdr.op   = req_r.op;
        wh_o.flit.hdr.addr = req_r.addr;
        if (wh_i.ready) state_n = is_store ? st_send_data : st_recv_hdr;
      end
      st_send_data: begin
        wh_o.v         = 1'b1;
        wh_o.flit.data = req_r.data;
        if (wh_i.ready) state_n = st_recv_hdr;
      end
      st_recv_hdr: begin
        wh_o.ready = 1'b1;
        if (wh_i.v) state_n = (wh_i.flit.hdr.len == '0) ? st_hold_resp : st_recv_data;
      end
      st_recv_data: begin
        wh_o.ready = 1'b1;
        if (wh_i.v) state_n = st_hold_resp;
      end
      st_hold_resp: begin
        if (resp_ready_i) state_n = st_idle;
      end
      default: state_n = st_idle;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge hb_clk_i or negedge arst_n) begin
    if (!arst_n) begin
      state_r <= st_idle;
      live_r  <= 1'b0;
    end else begin
      state_r <= state_n;
      live_r  <= 1'b1;
    end
  end

  // Request and response payload
  always_ff @(posedge hb_clk_i) begin
    if (req_fire) req_r <= req_i;
    if (flit_in_fire && state_r == st_recv_hdr) begin
      resp_r.op   <= gw_mc_pkg::mc_op_e'(wh_i.flit.hdr.op);
      resp_r.data <= '0;
    end
    if (flit_in_fire && state_r == st_recv_data) begin
      resp_r.data <= wh_i.flit.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Memory never answers with more than one payload flit
  resp_hdr_len_a : assert property (
    @(posedge hb_clk_i) disable iff (!arst_n)
    (flit_in_fire && state_r == st_recv_hdr) |-> (wh_i.flit.hdr.len <= 2'd1)
  ) else $error("response header announces len %0d", wh_i.flit.hdr.len);

endmodule

`default_nettype wire

// ==== source/gw_wormhole_test_mem.sv ====
`default_nettype none

module gw_wormhole_test_mem #(
  parameter int mem_words_p = 256
) (
  input  logic                 hb_clk_i,
  input  logic                 rst_n_i,
  input  logic                 mem_rst_i,
  input  gw_noc_pkg::wh_link_s wh_i,
  output gw_noc_pkg::wh_link_s wh_o
);

  localparam int idx_width_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

  typedef enum logic [1:0] {
    m_idle,
    m_recv_data,
    m_send_hdr,
    m_send_data
  } state_e;

  state_e                              state_r;
  logic                                arst_n;
  logic                                live_r;
  logic                                hdr_fire;
  logic                                data_fire;
  logic                                hdr_is_load;
  logic                                resp_is_load;
  gw_noc_pkg::wh_header_s              hdr_r;
  logic [gw_noc_pkg::flit_width_c-1:0] rdata_r;
  logic [gw_noc_pkg::flit_width_c-1:0] mem_r [mem_words_p];
  logic [mem_words_p-1:0]              written_r;

  // Word address wraps on the array size
  function automatic logic [idx_width_lp-1:0] word_idx(
    input logic [gw_noc_pkg::addr_width_c-1:0] addr
  );
    return idx_width_lp'((addr >> 2) % mem_words_p);
  endfunction

  assign arst_n = rst_n_i & ~mem_rst_i;

  assign hdr_fire     = (state_r == m_idle) && wh_i.v && wh_o.ready;
  assign data_fire    = (state_r == m_recv_data) && wh_i.v && wh_o.ready;
  assign hdr_is_load  = (wh_i.flit.hdr.op == gw_mc_pkg::mc_op_load);
  assign resp_is_load = (hdr_r.op == gw_mc_pkg::mc_op_load);

  //////////////////////////////////////////////////////////////////////
  // Response flits
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wh_o       = '0;
    wh_o.ready = live_r && (state_r == m_idle || state_r == m_recv_data);
    if (state_r == m_send_hdr) begin
      wh_o.v             = 1'b1;
      wh_o.flit.hdr.len  = resp_is_load ? 2'd1 : 2'd0;
      wh_o.flit.hdr.op   = resp_is_load ? gw_mc_pkg::mc_op_load : gw_mc_pkg::mc_op_ack;
      wh_o.flit.hdr.addr = hdr_r.addr;
    end else if (state_r == m_send_data) begin
      wh_o.v         = 1'b1;
      wh_o.flit.data = rdata_r;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control state and written map
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge hb_clk_i or negedge arst_n) begin
    if (!arst_n) begin
      state_r   <= m_idle;
      live_r    <= 1'b0;
      written_r <= '0;
    end else begin
      live_r <= 1'b1;
      case (state_r)
        m_idle:      if (hdr_fire) state_r <= hdr_is_load ? m_send_hdr : m_recv_data;
        m_recv_data: begin
          if (data_fire) begin
            written_r[word_idx(hdr_r.addr)] <= 1'b1;
            state_r                         <= m_send_hdr;
          end
        end
        m_send_hdr:  if (wh_i.ready) state_r <= resp_is_load ? m_send_data : m_idle;
        m_send_data: if (wh_i.ready) state_r <= m_idle;
        default:     state_r <= m_idle;
      endcase
    end
  end

  // Storage and read data
  always_ff @(posedge hb_clk_i) begin
    if (hdr_fire) begin
      hdr_r   <= wh_i.flit.hdr;
      // Unwritten words read as zero
      rdata_r <= written_r[word_idx(wh_i.flit.hdr.addr)] ?
                 mem_r[word_idx(wh_i.flit.hdr.addr)] : '0;
    end
    if (data_fire) mem_r[word_idx(hdr_r.addr)] <= wh_i.flit.data;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Ack is a response opcode only
  req_hdr_not_ack_a : assert property (
    @(posedge hb_clk_i) disable iff (!arst_n)
    hdr_fire |-> (wh_i.flit.hdr.op != gw_mc_pkg::mc_op_ack)
  ) else $error("request header carries op ack");

endmodule

`default_nettype wire

// ==== source/gw_core_complex.sv ====
`default_nettype none

module gw_core_complex #(
  parameter int mem_words_p = 256
) (
  input  logic                hb_clk_i,
  input  logic                rst_n_i,
  input  logic                tag_en_i,
  input  logic                tag_data_i,
  input  logic                tag_trace_done_i,
  input  logic                req_v_i,
  input  gw_mc_pkg::mc_req_s  req_i,
  input  logic                resp_ready_i,
  output logic                req_ready_o,
  output logic                resp_v_o,
  output gw_mc_pkg::mc_resp_s resp_o
);

  gw_mc_pkg::tag_payload_s tag_payload;
  logic                    core_rst;
  logic                    mem_rst;
  gw_noc_pkg::wh_link_s    req_link;
  gw_noc_pkg::wh_link_s    resp_link;

  //////////////////////////////////////////////////////////////////////
  // Tag client and derived resets
  //////////////////////////////////////////////////////////////////////

  gw_tag_client tag_client_i (
    .hb_clk_i      (hb_clk_i),
    .rst_n_i       (rst_n_i),
    .tag_en_i      (tag_en_i),
    .tag_data_i    (tag_data_i),
    .tag_new_o     (),
    .tag_payload_o (tag_payload)
  );

  assign core_rst = tag_payload.reset | ~rst_n_i;
  // Memory also waits for the trace loader
  assign mem_rst  = core_rst | ~tag_trace_done_i;

  //////////////////////////////////////////////////////////////////////
  // Adapter and test memory
  //////////////////////////////////////////////////////////////////////

  gw_mc_to_wormhole mc_adapter_i (
    .hb_clk_i     (hb_clk_i),
    .rst_n_i      (rst_n_i),
    .core_rst_i   (core_rst),
    .req_v_i      (req_v_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .resp_v_o     (resp_v_o),
    .resp_o       (resp_o),
    .resp_ready_i (resp_ready_i),
    .wh_i         (resp_link),
    .wh_o         (req_link)
  );

  gw_wormhole_test_mem #(
    .mem_words_p (mem_words_p)
  ) test_mem_i (
    .hb_clk_i  (hb_clk_i),
    .rst_n_i   (rst_n_i),
    .mem_rst_i (mem_rst),
    .wh_i      (req_link),
    .wh_o      (resp_link)
  );

endmodule

`default_nettype wire

// ==== tests/gw_tb_clock.sv ====
`default_nettype none

module gw_tb_clock #(
  parameter int half_period_p = 2
) (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(half_period_p) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== tests/gw_core_complex_tb.sv ====
`default_nettype none

module gw_core_complex_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int mem_words_lp   = 16;
  localparam int num_rows_lp    = 16;
  localparam int row_cycles_lp  = 100;
  localparam int watchdog_ns_lp = (num_rows_lp * row_cycles_lp + 40) * 4;

  typedef enum logic [1:0] {
    k_trace,
    k_tag,
    k_req
  } kind_e;

  // One step of the stimulus table
  typedef struct packed {
    kind_e             kind;
    logic [1:0]        tag_bits;
    gw_mc_pkg::mc_op_e op;
    logic [15:0]       addr;
    logic [31:0]       data;
    gw_mc_pkg::mc_op_e exp_op;
    logic [31:0]       exp_data;
  } row_s;

  logic                hb_clk;
  logic                rst_n;
  logic                tag_en;
  logic                tag_data;
  logic                tag_trace_done;
  logic                req_v;
  gw_mc_pkg::mc_req_s  req;
  logic                resp_ready;
  logic                req_ready;
  logic                resp_v;
  gw_mc_pkg::mc_resp_s resp;

  row_s        rows [num_rows_lp];
  logic [31:0] model_mem [mem_words_lp];
  logic        model_written [mem_words_lp];
  int          errors;

  gw_tb_clock clock_i (.clk_o(hb_clk));

  gw_core_complex #(
    .mem_words_p (mem_words_lp)
  ) gw_core_complex_i (
    .hb_clk_i         (hb_clk),
    .rst_n_i          (rst_n),
    .tag_en_i         (tag_en),
    .tag_data_i       (tag_data),
    .tag_trace_done_i (tag_trace_done),
    .req_v_i          (req_v),
    .req_i            (req),
    .resp_ready_i     (resp_ready),
    .req_ready_o      (req_ready),
    .resp_v_o         (resp_v),
    .resp_o           (resp)
  );

  ////////////////////////////////////////////////////////////////////////
  // Stimulus table and reference model
  ////////////////////////////////////////////////////////////////////////

  function automatic row_s make_row(kind_e kind, logic [1:0] bits, gw_mc_pkg::mc_op_e op,
                                    logic [15:0] addr, logic [31:0] data);
    row_s r;
    r          = '0;
    r.kind     = kind;
    r.tag_bits = bits;
    r.op       = op;
    r.addr     = addr;
    r.data     = data;
    return r;
  endfunction

  task automatic clear_model();
    for (int w = 0; w < mem_words_lp; w++) begin
      model_written[w] = 1'b0;
      model_mem[w]     = '0;
    end
  endtask

  // Walks the table through the store/load rules to fill expected values
  task automatic build_table();
    int idx;
    rows[0]  = make_row(k_trace, 2'b00, gw_mc_pkg::mc_op_load,  16'h0000, 32'h0);
    rows[1]  = make_row(k_trace, 2'b00, gw_mc_pkg::mc_op_load,  16'h0000, 32'h1);
    rows[2]  = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_store, 16'h0010, 32'hdeadbeef);
    rows[3]  = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_load,  16'h0010, 32'h0);
    rows[4]  = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_load,  16'h0020, 32'h0);
    rows[5]  = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_store, 16'h0004, 32'h12345678);
    rows[6]  = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_store, 16'h0044, 32'hcafef00d);
    rows[7]  = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_load,  16'h0004, 32'h0);
    rows[8]  = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_load,  16'h0084, 32'h0);
    rows[9]  = make_row(k_tag,   2'b01, gw_mc_pkg::mc_op_load,  16'h0000, 32'h0);
    rows[10] = make_row(k_tag,   2'b00, gw_mc_pkg::mc_op_load,  16'h0000, 32'h0);
    rows[11] = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_load,  16'h0010, 32'h0);
    rows[12] = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_store, 16'h0030, 32'ha5a50001);
    rows[13] = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_load,  16'h0030, 32'h0);
    rows[14] = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_store, 16'h0008, 32'h0badf00d);
    rows[15] = make_row(k_req,   2'b00, gw_mc_pkg::mc_op_load,  16'h0048, 32'h0);
    clear_model();
    for (int i = 0; i < num_rows_lp; i++) begin
      idx = int'(rows[i].addr >> 2) % mem_words_lp;
      case (rows[i].kind)
        k_trace: if (!rows[i].data[0]) clear_model();
        k_tag:   if (rows[i].tag_bits[0]) clear_model();
        default: begin
          if (rows[i].op == gw_mc_pkg::mc_op_store) begin
            model_mem[idx]     = rows[i].data;
            model_written[idx] = 1'b1;
            rows[i].exp_op     = gw_mc_pkg::mc_op_ack;
            rows[i].exp_data   = '0;
          end else begin
            rows[i].exp_op   = gw_mc_pkg::mc_op_load;
            rows[i].exp_data = model_written[idx] ? model_mem[idx] : '0;
          end
        end
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Drivers and checkers
  ////////////////////////////////////////////////////////////////////////

  // Host port stays closed until the memory leaves reset
  task automatic apply_trace(row_s r);
    tag_trace_done = r.data[0];
    if (!r.data[0]) begin
      req_v    = 1'b1;
      req.op   = r.op;
      req.addr = r.addr;
      req.data = r.data;
    end
    for (int c = 0; c < 12 && !r.data[0]; c++) begin
      @(negedge hb_clk);
      assert (!req_ready) else begin
        errors++;
        $display("%0t: req_ready_o high while trace-done is low", $time);
      end
      assert (!resp_v) else begin
        errors++;
        $display("%0t: response appeared while trace-done is low", $time);
      end
    end
    req_v = 1'b0;
    req   = '0;
    @(negedge hb_clk);
  endtask

  // Reset bit goes out first
  task automatic apply_tag(row_s r);
    tag_en   = 1'b1;
    tag_data = r.tag_bits[0];
    @(negedge hb_clk);
    tag_data = r.tag_bits[1];
    @(negedge hb_clk);
    tag_en   = 1'b0;
    tag_data = 1'b0;
    repeat (2) @(negedge hb_clk);
    for (int c = 0; c < 6 && r.tag_bits[0]; c++) begin
      assert (!req_ready) else begin
        errors++;
        $display("%0t: req_ready_o high while the tag reset is set", $time);
      end
      @(negedge hb_clk);
    end
  endtask

  task automatic apply_request(row_s r);
    gw_mc_pkg::mc_resp_s first;
    logic                taken;
    req_v   = 1'b1;
    req.op   = r.op;
    req.addr = r.addr;
    req.data = r.data;
    while (!req_ready) @(negedge hb_clk);
    @(negedge hb_clk);
    req_v = 1'b0;
    req   = '0;
    while (!resp_v) @(negedge hb_clk);
    first = resp;
    taken = 1'b0;
    while (!taken) begin
      assert (resp_v && resp == first) else begin
        errors++;
        $display("mismatch at %0t: resp_o changed while held, got %h expected %h",
                 $time, resp, first);
      end
      resp_ready = ($urandom % 3) != 0;
      taken      = resp_ready;
      @(negedge hb_clk);
    end
    resp_ready = 1'b0;
    assert (first.op == r.exp_op) else begin
      errors++;
      $display("mismatch at %0t: resp_o.op got %0d expected %0d", $time, first.op, r.exp_op);
    end
    assert (first.data == r.exp_data) else begin
      errors++;
      $display("mismatch at %0t: resp_o.data got %h expected %h",
               $time, first.data, r.exp_data);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////

  initial begin
    #(watchdog_ns_lp);
    $display("watchdog expired after %0d ns, the DUT stopped responding", watchdog_ns_lp);
    $display("errors: %0d", errors);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(85640));
    errors         = 0;
    rst_n          = 1'b0;
    tag_en         = 1'b0;
    tag_data       = 1'b0;
    tag_trace_done = 1'b0;
    req_v          = 1'b0;
    req            = '0;
    resp_ready     = 1'b0;
    build_table();
    repeat (5) @(negedge hb_clk);
    rst_n = 1'b1;
    @(negedge hb_clk);
    for (int i = 0; i < num_rows_lp; i++) begin
      case (rows[i].kind)
        k_trace: apply_trace(rows[i]);
        k_tag:   apply_tag(rows[i]);
        default: apply_request(rows[i]);
      endcase
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/gw_noc_pkg.sv
source/gw_mc_pkg.sv
source/gw_tag_client.sv
source/gw_mc_to_wormhole.sv
source/gw_wormhole_test_mem.sv
source/gw_core_complex.sv
tests/gw_tb_clock.sv
tests/gw_core_complex_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f \
  --top-module gw_core_complex_tb -o gw_sim || exit 1
./obj_dir/gw_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || grep -q '\*\*\* PASSED \*\*\*' sim.log
